// ==== Makefile ====
# Verilator build and run of the clock frequency monitor testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       ?= tb_clk_freq_monitor
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(filter-out +%,$(shell cat $(FLIST))) clk_mon_cfg.svh

.PHONY: all run clean

all: run

# Rebuilt only when a source, the header or the file list changes
$(SIM): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# Fails unless the pass line shows up in the output
run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^TESTS PASSED$$"

clean:
	rm -rf $(OBJ_DIR)

// ==== clk_freq_monitor.sv ====
`timescale 1ns/1ps
`default_nettype none

// Clock frequency monitor for the board clocks.
// One gate timer in ps_clk drives four identical channels, each
// reporting the edge count of its clock per gate interval.
module clk_freq_monitor
    import clk_mon_pkg::*;
(
    input  logic              ps_clk,
    input  logic              rst_n_i,

    // Measured clocks
    input  logic              adc_clk_i,
    input  logic              ref_clk_i,
    input  logic              aclk_i,
    input  logic              aclk_div2_i,

    // Results, ps_clk domain
    output logic [FREQ_W-1:0] adc_clk_freq_o,
    output logic [FREQ_W-1:0] ref_clk_freq_o,
    output logic [FREQ_W-1:0] aclk_freq_o,
    output logic [FREQ_W-1:0] aclk_div2_freq_o,
    output logic              adc_clk_valid_o,
    output logic              ref_clk_valid_o,
    output logic              aclk_valid_o,
    output logic              aclk_div2_valid_o
);

    logic gate; // Shared by all channels

    gate_timer u_gate (
        .ps_clk  (ps_clk),
        .rst_n_i (rst_n_i),
        .gate_o  (gate)
    );

    // Converter sample clock
    freq_channel u_adc_ch (
        .ps_clk       (ps_clk),
        .meas_clk_i   (adc_clk_i),
        .rst_n_i      (rst_n_i),
        .gate_i       (gate),
        .freq_o       (adc_clk_freq_o),
        .freq_valid_o (adc_clk_valid_o)
    );

    // PL reference clock
    freq_channel u_ref_ch (
        .ps_clk       (ps_clk),
        .meas_clk_i   (ref_clk_i),
        .rst_n_i      (rst_n_i),
        .gate_i       (gate),
        .freq_o       (ref_clk_freq_o),
        .freq_valid_o (ref_clk_valid_o)
    );

    // Stream clock
    freq_channel u_aclk_ch (
        .ps_clk       (ps_clk),
        .meas_clk_i   (aclk_i),
        .rst_n_i      (rst_n_i),
        .gate_i       (gate),
        .freq_o       (aclk_freq_o),
        .freq_valid_o (aclk_valid_o)
    );

    // Halved stream clock
    freq_channel u_aclk_div2_ch (
        .ps_clk       (ps_clk),
        .meas_clk_i   (aclk_div2_i),
        .rst_n_i      (rst_n_i),
        .gate_i       (gate),
        .freq_o       (aclk_div2_freq_o),
        .freq_valid_o (aclk_div2_valid_o)
    );

endmodule

`default_nettype wire

// ==== clk_mon_cfg.svh ====
`ifndef CLK_MON_CFG_SVH
`define CLK_MON_CFG_SVH

// ps_clk cycles per gate interval
// 1000 keeps simulation short, the board build uses 100000000 (1 s at 100 MHz)
`define CLK_MON_GATE_CYCLES 1000

// Width of the edge counters and of every reported result
`define CLK_MON_FREQ_W 32

// Synchronizer flops per crossing, at least 2
`define CLK_MON_SYNC_STAGES 3

`endif

// ==== clk_mon_pkg.sv ====
`default_nettype none

`include "clk_mon_cfg.svh"

package clk_mon_pkg;

    // Gate timer counts 0 .. GATE_CYCLES-1
    localparam int unsigned GATE_CNT_W = $clog2(`CLK_MON_GATE_CYCLES);

    // Last count before the gate timer wraps
    localparam logic [GATE_CNT_W-1:0] GATE_LAST = GATE_CNT_W'(`CLK_MON_GATE_CYCLES - 1);

    // Edge count and result width
    localparam int unsigned FREQ_W = `CLK_MON_FREQ_W;

endpackage

`default_nettype wire

// ==== flag_sync.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "clk_mon_cfg.svh"

// Single-cycle pulse crossing between two unrelated clocks.
// The source side turns each pulse into a level change, the destination
// side resynchronizes that level and turns each change back into a pulse.
// Pulses must be spaced well apart compared to the chain length.
module flag_sync (
    input  logic src_clk_i,
    input  logic dst_clk_i,
    input  logic rst_n_i,
    input  logic flag_i,
    output logic flag_o
);

    logic                            toggle_q;
    logic [`CLK_MON_SYNC_STAGES-1:0] sync_q;

    // Source side
    always_ff @(posedge src_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            toggle_q <= 1'b0;
        end else if (flag_i) begin
            toggle_q <= ~toggle_q; // One flip per pulse
        end
    end

    // Destination side, sync_q[0] is the metastable stage
    always_ff @(posedge dst_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            sync_q <= '0;
        end else begin
            sync_q <= {sync_q[`CLK_MON_SYNC_STAGES-2:0], toggle_q};
        end
    end

    // Any change at the end of the chain is one pulse
    assign flag_o = sync_q[`CLK_MON_SYNC_STAGES-1] ^ sync_q[`CLK_MON_SYNC_STAGES-2];

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+.
clk_mon_pkg.sv
flag_sync.sv
gate_timer.sv
freq_channel.sv
clk_freq_monitor.sv
tb_clk_freq_monitor.sv

// ==== freq_channel.sv ====
`timescale 1ns/1ps
`default_nettype none

// Frequency measurement for one clock.
// The ps_clk gate is carried into the measured domain, where it closes
// one counting interval and opens the next. The closed count is held
// in a latch while a done flag travels back to ps_clk, which then loads
// the count into freq_o and pulses freq_valid_o.
module freq_channel
    import clk_mon_pkg::*;
(
    input  logic              ps_clk,
    input  logic              meas_clk_i,
    input  logic              rst_n_i,
    input  logic              gate_i,
    output logic [FREQ_W-1:0] freq_o,
    output logic              freq_valid_o
);

    // Measured clock domain
    logic              gate_meas;   // Gate as seen by meas_clk_i
    logic [FREQ_W-1:0] edge_cnt_q;
    logic [FREQ_W-1:0] latch_q;     // Held until the next gate
    logic              done_q;

    // ps_clk domain
    logic              done_ps;

    flag_sync u_gate_sync (
        .src_clk_i (ps_clk),
        .dst_clk_i (meas_clk_i),
        .rst_n_i   (rst_n_i),
        .flag_i    (gate_i),
        .flag_o    (gate_meas)
    );

    // Edge counter cleared by each gate
    always_ff @(posedge meas_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            edge_cnt_q <= '0;
        end else if (gate_meas) begin
            edge_cnt_q <= '0;
        end else begin
            edge_cnt_q <= edge_cnt_q + 1'b1;
        end
    end

    // Count closes on the gate cycle.
    // The +1 takes in the edge on which the counter restarted.
    always_ff @(posedge meas_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            latch_q <= '0;
        end else if (gate_meas) begin
            latch_q <= edge_cnt_q + 1'b1;
        end
    end

    // Done trails the latch by one cycle so the value is settled
    always_ff @(posedge meas_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            done_q <= 1'b0;
        end else begin
            done_q <= gate_meas;
        end
    end

    flag_sync u_done_sync (
        .src_clk_i (meas_clk_i),
        .dst_clk_i (ps_clk),
        .rst_n_i   (rst_n_i),
        .flag_i    (done_q),
        .flag_o    (done_ps)
    );

    // Result register loaded by the returned done pulse
    always_ff @(posedge ps_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            freq_o <= '0;
        end else if (done_ps) begin
            freq_o <= latch_q;
        end
    end

    always_ff @(posedge ps_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            freq_valid_o <= 1'b0;
        end else begin
            freq_valid_o <= done_ps; // Same cycle freq_o changes
        end
    end

endmodule

`default_nettype wire

// ==== gate_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

// Periodic gate for the frequency channels.
// gate_o is high for one ps_clk cycle every GATE_CYCLES cycles,
// the first time right after reset is released.
module gate_timer
    import clk_mon_pkg::*;
(
    input  logic ps_clk,
    input  logic rst_n_i,
    output logic gate_o
);

    logic [GATE_CNT_W-1:0] cnt_q;

    // Free-running interval counter
    always_ff @(posedge ps_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cnt_q <= '0;
        end else if (cnt_q == GATE_LAST) begin
            cnt_q <= '0;
        end else begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    // Strobe registered off the zero count
    always_ff @(posedge ps_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            gate_o <= 1'b0;
        end else begin
            gate_o <= (cnt_q == '0);
        end
    end

endmodule

`default_nettype wire

// ==== tb_clk_freq_monitor.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "clk_mon_cfg.svh"

module tb_clk_freq_monitor;

    localparam int  FW           = `CLK_MON_FREQ_W;
    localparam int  GATE         = `CLK_MON_GATE_CYCLES;
    localparam int  STROBE_LIMIT = 3 * GATE; // ps_clk cycles
    localparam real PS_PERIOD    = 10.0;

    logic ps_clk    = 1'b0;
    logic rst_n     = 1'b0;
    logic adc_clk   = 1'b0;
    logic ref_clk   = 1'b0;
    logic aclk      = 1'b0;
    logic aclk_div2 = 1'b0;

    // Half periods in ns
    real  adc_half       = 2.0;
    real  ref_half       = 6.65;
    real  aclk_half      = 2.5;
    real  aclk_div2_half = 5.0;
    logic ref_run        = 1'b1; // Cleared to stop ref_clk

    logic [FW-1:0] adc_clk_freq;
    logic [FW-1:0] ref_clk_freq;
    logic [FW-1:0] aclk_freq;
    logic [FW-1:0] aclk_div2_freq;
    logic          adc_clk_valid;
    logic          ref_clk_valid;
    logic          aclk_valid;
    logic          aclk_div2_valid;

    // Channel order 0 adc, 1 ref, 2 aclk, 3 aclk_div2
    logic [3:0]    valid_vec;
    logic [FW-1:0] got_freq [4]; // Value seen on the latest strobe

    int checks = 0;
    int errors = 0;

    always #5 ps_clk = ~ps_clk;

    always begin
        #(adc_half);
        adc_clk = ~adc_clk;
    end

    always begin
        #(ref_half);
        if (ref_run) begin
            ref_clk = ~ref_clk;
        end
    end

    always begin
        #(aclk_half);
        aclk = ~aclk;
    end

    always begin
        #(aclk_div2_half);
        aclk_div2 = ~aclk_div2;
    end

    clk_freq_monitor dut0 (
        .ps_clk            (ps_clk),
        .rst_n_i           (rst_n),
        .adc_clk_i         (adc_clk),
        .ref_clk_i         (ref_clk),
        .aclk_i            (aclk),
        .aclk_div2_i       (aclk_div2),
        .adc_clk_freq_o    (adc_clk_freq),
        .ref_clk_freq_o    (ref_clk_freq),
        .aclk_freq_o       (aclk_freq),
        .aclk_div2_freq_o  (aclk_div2_freq),
        .adc_clk_valid_o   (adc_clk_valid),
        .ref_clk_valid_o   (ref_clk_valid),
        .aclk_valid_o      (aclk_valid),
        .aclk_div2_valid_o (aclk_div2_valid)
    );

    assign valid_vec = {aclk_div2_valid, aclk_valid, ref_clk_valid, adc_clk_valid};

    function automatic string chan_prefix(input int ch);
        case (ch)
            0:       return "adc_clk";
            1:       return "ref_clk";
            2:       return "aclk";
            default: return "aclk_div2";
        endcase
    endfunction

    function automatic logic [FW-1:0] freq_of(input int ch);
        case (ch)
            0:       return adc_clk_freq;
            1:       return ref_clk_freq;
            2:       return aclk_freq;
            default: return aclk_div2_freq;
        endcase
    endfunction

    // Edges per gate interval, one count either way
    function automatic int count_low(input real period_ns);
        real x;
        x = GATE * PS_PERIOD / period_ns;
        return $rtoi($ceil(x - 1.0));
    endfunction

    function automatic int count_high(input real period_ns);
        real x;
        x = GATE * PS_PERIOD / period_ns;
        return $rtoi($floor(x + 1.0));
    endfunction

    task automatic check_equal(input string name, input logic [FW-1:0] value,
                               input logic [FW-1:0] expected);
        checks++;
        assert (value === expected) else begin
            $display("FAIL %s expected %0h got %0h", name, expected, value);
            errors++;
        end
    endtask

    task automatic check_range(input string name, input logic [FW-1:0] value,
                               input int lo, input int hi);
        checks++;
        assert ((int'(value) >= lo) && (int'(value) <= hi)) else begin
            $display("FAIL %s expected %0h..%0h got %0h", name, lo, hi, value);
            errors++;
        end
    endtask

    task automatic check_count(input int ch, input real period_ns);
        check_range({chan_prefix(ch), "_freq_o"}, got_freq[ch],
                    count_low(period_ns), count_high(period_ns));
    endtask

    // All results zero, no strobe
    task automatic check_idle();
        int ch;
        for (ch = 0; ch < 4; ch++) begin
            check_equal({chan_prefix(ch), "_freq_o"}, freq_of(ch), '0);
            check_equal({chan_prefix(ch), "_valid_o"}, {{(FW-1){1'b0}}, valid_vec[ch]}, '0);
        end
    endtask

    // Collects one strobe per masked channel, gives up after three gate intervals
    task automatic wait_strobes(input logic [3:0] mask, output logic [3:0] seen,
                                output int waited);
        int n;
        int ch;
        seen = 4'b0000;
        n    = 0;
        while (((seen & mask) != mask) && (n < STROBE_LIMIT)) begin
            @(negedge ps_clk);
            n++;
            for (ch = 0; ch < 4; ch++) begin
                if (mask[ch] && !seen[ch] && valid_vec[ch]) begin
                    seen[ch]     = 1'b1;
                    got_freq[ch] = freq_of(ch);
                end
            end
        end
        waited = n;
    endtask

    task automatic check_seen(input logic [3:0] mask, input logic [3:0] seen);
        int ch;
        for (ch = 0; ch < 4; ch++) begin
            if (mask[ch]) begin
                checks++;
                assert (seen[ch]) else begin
                    $display("Timeout: no %s_valid_o strobe within three gate intervals",
                             chan_prefix(ch));
                    errors++;
                end
            end
        end
    endtask

    task automatic report_test(input string name, input int err_start);
        if (errors == err_start) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - err_start);
        end
    endtask

    task automatic test_reset_state();
        int err_start;
        int n;
        err_start = errors;
        for (n = 0; n < 3; n++) begin
            @(negedge ps_clk);
            check_idle();
        end
        @(posedge ps_clk);
        rst_n <= 1'b1;
        // Nothing can have crossed back yet
        for (n = 0; n < 4; n++) begin
            @(negedge ps_clk);
            check_idle();
        end
        report_test("reset_state", err_start);
    endtask

    task automatic test_adc_ref();
        int         err_start;
        logic [3:0] seen;
        int         waited;
        err_start = errors;
        wait_strobes(4'b1111, seen, waited); // Partial first interval
        check_seen(4'b1111, seen);
        wait_strobes(4'b1111, seen, waited);
        check_seen(4'b1111, seen);
        check_count(0, 4.0);
        check_count(1, 13.3);
        report_test("adc_ref_counts", err_start);
    endtask

    task automatic test_aclk_pair();
        int         err_start;
        logic [3:0] seen;
        int         waited;
        err_start = errors;
        wait_strobes(4'b1111, seen, waited);
        check_seen(4'b1111, seen);
        check_count(2, 5.0);
        check_count(3, 10.0);
        report_test("aclk_pair_counts", err_start);
    endtask

    task automatic test_adc_period_change();
        int         err_start;
        logic [3:0] seen;
        int         waited;
        err_start = errors;
        adc_half = 4.0;
        // adc interval in flight is mixed
        wait_strobes(4'b1111, seen, waited);
        check_seen(4'b1111, seen);
        check_count(1, 13.3);
        check_count(2, 5.0);
        check_count(3, 10.0);
        wait_strobes(4'b1111, seen, waited);
        check_seen(4'b1111, seen);
        check_count(0, 8.0);
        check_count(1, 13.3);
        check_count(2, 5.0);
        check_count(3, 10.0);
        report_test("adc_period_change", err_start);
    endtask

    task automatic test_ref_stop();
        int            err_start;
        logic [3:0]    seen;
        int            waited;
        logic [FW-1:0] held;
        err_start = errors;
        held      = ref_clk_freq;
        ref_run   = 1'b0;
        wait_strobes(4'b0010, seen, waited);
        checks++;
        assert (!seen[1]) else begin
            $display("ref_clk_valid_o strobed while the reference clock was stopped");
            errors++;
        end
        check_equal("ref_clk_freq_o", ref_clk_freq, held);
        // One more gate so the gate toggle flipped an even number of times
        repeat (GATE) @(negedge ps_clk);
        check_equal("ref_clk_freq_o", ref_clk_freq, held);
        ref_run = 1'b1;
        wait_strobes(4'b0010, seen, waited); // Spans the stop
        check_seen(4'b0010, seen);
        wait_strobes(4'b0010, seen, waited);
        check_seen(4'b0010, seen);
        check_count(1, 13.3);
        report_test("ref_clock_stop", err_start);
    endtask

    task automatic test_strobe_spacing();
        int         err_start;
        logic [3:0] seen;
        int         waited;
        err_start = errors;
        wait_strobes(4'b0001, seen, waited);
        check_seen(4'b0001, seen);
        wait_strobes(4'b0001, seen, waited);
        check_seen(4'b0001, seen);
        check_range("adc_clk_valid_o spacing", waited, GATE - 2, GATE + 2);
        report_test("strobe_spacing", err_start);
    endtask

    initial begin
        test_reset_state();
        test_adc_ref();
        test_aclk_pair();
        test_adc_period_change();
        test_ref_stop();
        test_strobe_spacing();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
